// File: rtl/cdc_defs.svh
// CDC merger configuration
`ifndef CDC_DEFS_SVH
`define CDC_DEFS_SVH

// each channel FIFO holds 2**CDC_LOG_DEPTH entries
// the pointers carry one extra bit so that full and empty can be told apart
`define CDC_LOG_DEPTH 3

// number of flip-flops every pointer bit passes when it enters the other domain
`define CDC_SYNC_STAGES 2

// width of one payload word on either producer channel
`define CDC_DATA_W 16

`endif

// File: rtl/cdc_fifo_dst.sv
// CDC FIFO destination half
`timescale 1ns/1ns
`default_nettype none

`include "cdc_defs.svh"

// read side of the gray pointer FIFO in the consumer clock domain
// the word is picked straight out of the source storage
module cdc_fifo_dst import cdc_pkg::*; (
  input  logic                                dst_clk_i,
  input  logic                                arst_n_i,
  input  fifo_entry_t [2**`CDC_LOG_DEPTH-1:0] async_data_i,
  input  logic [`CDC_LOG_DEPTH:0]             async_wptr_i,
  output logic [`CDC_LOG_DEPTH:0]             async_rptr_o,
  output fifo_entry_t                         entry_o,
  output logic                                valid_o,
  input  logic                                ready_i
);

  localparam int ptr_w = `CDC_LOG_DEPTH + 1;

  logic [ptr_w-1:0] rptr_q;
  logic [ptr_w-1:0] rptr_d;
  logic [ptr_w-1:0] rgray_q;
  logic [ptr_w-1:0] wptr_bin;
  logic             read;

  // the write pointer only shows a slot after its data has been stable
  // for the whole synchronizer delay, so the data bus needs no synchronizer
  gray_ptr_sync wptr_sync_i (
    .clk_i    (dst_clk_i),
    .arst_n_i (arst_n_i),
    .gray_i   (async_wptr_i),
    .bin_o    (wptr_bin)
  );

  // any difference between the pointers means at least one word is waiting
  assign valid_o = wptr_bin != rptr_q;
  assign entry_o = async_data_i[rptr_q[`CDC_LOG_DEPTH-1:0]];

  assign read   = valid_o & ready_i;
  assign rptr_d = rptr_q + ptr_w'(read);

  // binary count for addressing and a registered gray copy for the return path
  always_ff @(posedge dst_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rptr_q  <= '0;
      rgray_q <= '0;
    end else begin
      rptr_q  <= rptr_d;
      rgray_q <= rptr_d ^ (rptr_d >> 1);
    end
  end

  // freed slots reach the producer after its own synchronizer delay
  assign async_rptr_o = rgray_q;

endmodule

`default_nettype wire

// File: rtl/cdc_fifo_src.sv
// CDC FIFO source half
`timescale 1ns/1ns
`default_nettype none

`include "cdc_defs.svh"

// write side of the gray pointer FIFO in the producer clock domain
// the storage lives here and is read directly by the destination half
module cdc_fifo_src import cdc_pkg::*; (
  input  logic                                src_clk_i,
  input  logic                                arst_n_i,
  input  chan_word_t                          data_i,
  input  logic                                last_i,
  input  logic                                valid_i,
  output logic                                ready_o,
  output fifo_entry_t [2**`CDC_LOG_DEPTH-1:0] async_data_o,
  output logic [`CDC_LOG_DEPTH:0]             async_wptr_o,
  input  logic [`CDC_LOG_DEPTH:0]             async_rptr_i
);

  localparam int depth = 2**`CDC_LOG_DEPTH;
  localparam int ptr_w = `CDC_LOG_DEPTH + 1;
  // pointers that differ only in the top bit mean the FIFO is full
  localparam logic [ptr_w-1:0] ptr_full = ptr_w'(depth);

  fifo_entry_t [depth-1:0] data_q;
  fifo_entry_t             wr_entry;
  logic [ptr_w-1:0]        wptr_q;
  logic [ptr_w-1:0]        wptr_d;
  logic [ptr_w-1:0]        wgray_q;
  logic [ptr_w-1:0]        rptr_bin;
  logic                    write;

  assign wr_entry = '{last: last_i, data: data_i};
  assign write    = valid_i & ready_o;
  assign wptr_d   = wptr_q + ptr_w'(write);

  // the slot is addressed by the low bits of the binary write pointer
  always_ff @(posedge src_clk_i) begin
    if (write) begin
      data_q[wptr_q[`CDC_LOG_DEPTH-1:0]] <= wr_entry;
    end
  end

  // the read pointer from the consumer arrives late, so free space looks smaller
  // than it really is and the FIFO can never overflow
  gray_ptr_sync rptr_sync_i (
    .clk_i    (src_clk_i),
    .arst_n_i (arst_n_i),
    .gray_i   (async_rptr_i),
    .bin_o    (rptr_bin)
  );

  // the gray copy is registered so the crossing sees a clean single bit change
  // ready is computed one edge ahead from the next write pointer and stays low in reset
  always_ff @(posedge src_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wptr_q  <= '0;
      wgray_q <= '0;
      ready_o <= 1'b0;
    end else begin
      wptr_q  <= wptr_d;
      wgray_q <= wptr_d ^ (wptr_d >> 1);
      ready_o <= (wptr_d ^ rptr_bin) != ptr_full;
    end
  end

  assign async_wptr_o = wgray_q;
  assign async_data_o = data_q;

endmodule

`default_nettype wire

// File: rtl/cdc_merge_top.sv
// CDC packet merger top level
`timescale 1ns/1ns
`default_nettype none

`include "cdc_defs.svh"

// two producers in the source domain, one merged stream in the destination domain
// both domains share one asynchronous power on reset
module cdc_merge_top import cdc_pkg::*; (
  input  logic       src_clk_i,
  input  logic       dst_clk_i,
  input  logic       arst_n_i,
  input  chan_word_t src0_data_i,
  input  logic       src0_last_i,
  input  logic       src0_valid_i,
  output logic       src0_ready_o,
  input  chan_word_t src1_data_i,
  input  logic       src1_last_i,
  input  logic       src1_valid_i,
  output logic       src1_ready_o,
  output chan_word_t out_data_o,
  output logic       out_src_o,
  output logic       out_last_o,
  output logic       out_valid_o,
  input  logic       out_ready_i
);

  // storage and gray pointers that cross between the two FIFO halves of each channel
  fifo_entry_t [2**`CDC_LOG_DEPTH-1:0] ch0_async_data;
  fifo_entry_t [2**`CDC_LOG_DEPTH-1:0] ch1_async_data;
  logic [`CDC_LOG_DEPTH:0]             ch0_async_wptr;
  logic [`CDC_LOG_DEPTH:0]             ch0_async_rptr;
  logic [`CDC_LOG_DEPTH:0]             ch1_async_wptr;
  logic [`CDC_LOG_DEPTH:0]             ch1_async_rptr;

  // destination side between each FIFO and its spill register
  fifo_entry_t ch0_fifo_entry;
  fifo_entry_t ch1_fifo_entry;
  logic        ch0_fifo_valid;
  logic        ch1_fifo_valid;
  logic        ch0_fifo_ready;
  logic        ch1_fifo_ready;
  fifo_entry_t ch0_spill_entry;
  fifo_entry_t ch1_spill_entry;

  stream_if #(.T(chan_word_t))   ch0_s ();
  stream_if #(.T(chan_word_t))   ch1_s ();
  stream_if #(.T(merged_word_t)) merged_s ();

  cdc_fifo_src ch0_src_i (
    .src_clk_i    (src_clk_i),
    .arst_n_i     (arst_n_i),
    .data_i       (src0_data_i),
    .last_i       (src0_last_i),
    .valid_i      (src0_valid_i),
    .ready_o      (src0_ready_o),
    .async_data_o (ch0_async_data),
    .async_wptr_o (ch0_async_wptr),
    .async_rptr_i (ch0_async_rptr)
  );

  cdc_fifo_dst ch0_dst_i (
    .dst_clk_i    (dst_clk_i),
    .arst_n_i     (arst_n_i),
    .async_data_i (ch0_async_data),
    .async_wptr_i (ch0_async_wptr),
    .async_rptr_o (ch0_async_rptr),
    .entry_o      (ch0_fifo_entry),
    .valid_o      (ch0_fifo_valid),
    .ready_i      (ch0_fifo_ready)
  );

  spill_reg #(.T(fifo_entry_t)) ch0_spill_i (
    .clk_i    (dst_clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (ch0_fifo_valid),
    .ready_o  (ch0_fifo_ready),
    .data_i   (ch0_fifo_entry),
    .valid_o  (ch0_s.valid),
    .ready_i  (ch0_s.ready),
    .data_o   (ch0_spill_entry)
  );

  cdc_fifo_src ch1_src_i (
    .src_clk_i    (src_clk_i),
    .arst_n_i     (arst_n_i),
    .data_i       (src1_data_i),
    .last_i       (src1_last_i),
    .valid_i      (src1_valid_i),
    .ready_o      (src1_ready_o),
    .async_data_o (ch1_async_data),
    .async_wptr_o (ch1_async_wptr),
    .async_rptr_i (ch1_async_rptr)
  );

  cdc_fifo_dst ch1_dst_i (
    .dst_clk_i    (dst_clk_i),
    .arst_n_i     (arst_n_i),
    .async_data_i (ch1_async_data),
    .async_wptr_i (ch1_async_wptr),
    .async_rptr_o (ch1_async_rptr),
    .entry_o      (ch1_fifo_entry),
    .valid_o      (ch1_fifo_valid),
    .ready_i      (ch1_fifo_ready)
  );

  spill_reg #(.T(fifo_entry_t)) ch1_spill_i (
    .clk_i    (dst_clk_i),
    .arst_n_i (arst_n_i),
    .valid_i  (ch1_fifo_valid),
    .ready_o  (ch1_fifo_ready),
    .data_i   (ch1_fifo_entry),
    .valid_o  (ch1_s.valid),
    .ready_i  (ch1_s.ready),
    .data_o   (ch1_spill_entry)
  );

  // the FIFO slot splits back into word and last on the channel streams
  assign ch0_s.data = ch0_spill_entry.data;
  assign ch0_s.last = ch0_spill_entry.last;
  assign ch1_s.data = ch1_spill_entry.data;
  assign ch1_s.last = ch1_spill_entry.last;

  packet_arbiter arbiter_i (
    .ch0       (ch0_s),
    .ch1       (ch1_s),
    .merged    (merged_s),
    .dst_clk_i (dst_clk_i),
    .arst_n_i  (arst_n_i)
  );

  assign out_data_o     = merged_s.data.data;
  assign out_src_o      = merged_s.data.src_id;
  assign out_last_o     = merged_s.last;
  assign out_valid_o    = merged_s.valid;
  assign merged_s.ready = out_ready_i;

endmodule

`default_nettype wire

// File: rtl/cdc_pkg.sv
// CDC merger types
`default_nettype none

`include "cdc_defs.svh"

package cdc_pkg;

  // one data word as a producer presents it
  typedef logic [`CDC_DATA_W-1:0] chan_word_t;

  // a FIFO slot keeps the word together with its end of packet flag
  // both FIFO halves see the same layout through the async data bus
  typedef struct packed {
    logic       last;
    chan_word_t data;
  } fifo_entry_t;

  // the merged stream tags every word with the channel it came from
  // src_id is 0 for the first producer and 1 for the second
  typedef struct packed {
    logic       src_id;
    chan_word_t data;
  } merged_word_t;

endpackage

`default_nettype wire

// File: rtl/gray_ptr_sync.sv
// Gray pointer synchronizer
`timescale 1ns/1ns
`default_nettype none

`include "cdc_defs.svh"

// brings a gray coded FIFO pointer into the local clock domain
// and hands it on as a binary count
module gray_ptr_sync (
  input  logic                    clk_i,
  input  logic                    arst_n_i,
  input  logic [`CDC_LOG_DEPTH:0] gray_i,
  output logic [`CDC_LOG_DEPTH:0] bin_o
);

  localparam int ptr_w = `CDC_LOG_DEPTH + 1;

  // stage 0 samples the foreign pointer and may go metastable
  // only one bit flips per pointer step so a late bit just shows the old value
  logic [ptr_w-1:0] sync_q [`CDC_SYNC_STAGES];
  logic [ptr_w-1:0] gray_s;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      for (int s = 0; s < `CDC_SYNC_STAGES; s++) begin
        sync_q[s] <= '0;
      end
    end else begin
      sync_q[0] <= gray_i;
      for (int s = 1; s < `CDC_SYNC_STAGES; s++) begin
        sync_q[s] <= sync_q[s-1];
      end
    end
  end

  assign gray_s = sync_q[`CDC_SYNC_STAGES-1];

  // binary bit i is the xor of all gray bits from i upward
  always_comb begin
    for (int i = 0; i < ptr_w; i++) begin
      bin_o[i] = ^(gray_s >> i);
    end
  end

endmodule

`default_nettype wire

// File: rtl/packet_arbiter.sv
// Round robin packet arbiter
`timescale 1ns/1ns
`default_nettype none

// merges two packet streams onto one without splitting any packet
// the output follows the granted channel with no added latency
module packet_arbiter import cdc_pkg::*; (
  stream_if.rx ch0,
  stream_if.rx ch1,
  stream_if.tx merged,
  input  logic dst_clk_i,
  input  logic arst_n_i
);

  // grant_q selects the channel on the output
  // open_q is set while a packet has started but its last beat is still to come
  // prio_q names the channel that goes first when the stream is free
  logic         grant_q;
  logic         open_q;
  logic         prio_q;
  logic         sel_valid;
  logic         sel_last;
  logic         prio_valid;
  logic         other_valid;
  logic         fire;
  logic         last_fire;
  chan_word_t   sel_data;
  merged_word_t out_word;

  assign sel_valid = grant_q ? ch1.valid : ch0.valid;
  assign sel_data  = grant_q ? ch1.data  : ch0.data;
  assign sel_last  = grant_q ? ch1.last  : ch0.last;

  assign out_word     = '{src_id: grant_q, data: sel_data};
  assign merged.valid = sel_valid;
  assign merged.data  = out_word;
  assign merged.last  = sel_last;

  // the channel without the grant sees ready low and keeps its word
  assign ch0.ready = merged.ready & ~grant_q;
  assign ch1.ready = merged.ready & grant_q;

  assign fire      = sel_valid & merged.ready;
  assign last_fire = fire & sel_last;

  assign prio_valid  = prio_q ? ch1.valid : ch0.valid;
  assign other_valid = prio_q ? ch0.valid : ch1.valid;

  always_ff @(posedge dst_clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      grant_q <= 1'b0;
      open_q  <= 1'b0;
      prio_q  <= 1'b0;
    end else if (last_fire) begin
      // a finished packet passes the grant and the priority to the other channel
      grant_q <= ~grant_q;
      prio_q  <= ~grant_q;
      open_q  <= 1'b0;
    end else if (fire) begin
      open_q <= 1'b1;
    end else if (!open_q && !sel_valid) begin
      // the granted channel is idle between packets so the grant may move
      // the output shows no valid here, so no offered beat is pulled back
      if (prio_valid) begin
        grant_q <= prio_q;
      end else if (other_valid) begin
        grant_q <= ~prio_q;
      end
    end
  end

endmodule

`default_nettype wire

// File: rtl/spill_reg.sv
// Two entry spill register
`timescale 1ns/1ns
`default_nettype none

// breaks both the valid and the ready path of a stream
// slot a takes new words and slot b catches a word the consumer refused
module spill_reg #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  T     a_data_q;
  T     b_data_q;
  logic a_full_q;
  logic b_full_q;
  logic a_full_d;
  logic b_full_d;
  logic a_fill;
  logic a_drain;
  logic b_fill;
  logic b_drain;

  assign a_fill  = valid_i & ready_o;
  // slot a empties whenever b is free, either to the output or into b
  assign a_drain = a_full_q & ~b_full_q;
  assign b_fill  = a_drain & ~ready_i;
  assign b_drain = b_full_q & ready_i;

  assign a_full_d = a_fill | (a_full_q & ~a_drain);
  assign b_full_d = b_fill | (b_full_q & ~b_drain);

  // the control state and ready all come out of flops
  // so ready_i never reaches ready_o in the same cycle
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
      ready_o  <= 1'b0;
    end else begin
      a_full_q <= a_full_d;
      b_full_q <= b_full_d;
      ready_o  <= ~(a_full_d & b_full_d);
    end
  end

  always_ff @(posedge clk_i) begin
    if (a_fill) begin
      a_data_q <= data_i;
    end
    if (b_fill) begin
      b_data_q <= a_data_q;
    end
  end

  // slot b always holds the older word when both are full
  assign valid_o = a_full_q | b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;

endmodule

`default_nettype wire

// File: rtl/stream_if.sv
// Packet stream interface
`timescale 1ns/1ns
`default_nettype none

// a valid/ready stream of packets whose payload type is chosen per instance
// a beat moves on the clock edge where valid and ready are both high
interface stream_if #(
  parameter type T = logic
) ();

  logic valid;
  logic ready;
  T     data;
  // marks the final beat of a packet
  logic last;

  // the sender holds valid, data and last steady until the beat is taken
  modport tx (
    output valid,
    output data,
    output last,
    input  ready
  );

  // the receiver only answers with ready
  modport rx (
    input  valid,
    input  data,
    input  last,
    output ready
  );

endinterface

`default_nettype wire

// File: sources.f
+incdir+rtl
rtl/cdc_pkg.sv
rtl/stream_if.sv
rtl/gray_ptr_sync.sv
rtl/cdc_fifo_src.sv
rtl/cdc_fifo_dst.sv
rtl/spill_reg.sv
rtl/packet_arbiter.sv
rtl/cdc_merge_top.sv
tests/tb_cdc_merge.sv

// File: tests/tb_cdc_merge.sv
// CDC merger testbench
`timescale 1ns/1ns
`default_nettype none

module tb_cdc_merge;

  // one row is one packet whose words count upward from start
  // rows with hold set are offered while out_ready_i is held low
  typedef struct packed {
    logic        ch;
    logic [2:0]  len;
    logic [15:0] start;
    logic        hold;
  } row_t;

  localparam int num_rows = 12;
  localparam row_t row_table [num_rows] = '{
    '{1'b0, 3'd6, 16'h0100, 1'b1},
    '{1'b0, 3'd6, 16'h0200, 1'b1},
    '{1'b1, 3'd4, 16'h1100, 1'b1},
    '{1'b1, 3'd5, 16'h1200, 1'b1},
    '{1'b0, 3'd1, 16'h0300, 1'b0},
    '{1'b1, 3'd3, 16'h1300, 1'b0},
    '{1'b0, 3'd5, 16'h0400, 1'b0},
    '{1'b1, 3'd6, 16'h1400, 1'b0},
    '{1'b1, 3'd2, 16'h1500, 1'b0},
    '{1'b0, 3'd4, 16'h0500, 1'b0},
    '{1'b0, 3'd2, 16'h0600, 1'b0},
    '{1'b1, 3'd1, 16'h1600, 1'b0}
  };

  // 8 FIFO slots plus the 2 spill register entries
  localparam int fifo_beats     = 10;
  localparam int bp_window      = 60;
  localparam int ready_low_span = 20;
  localparam int beat_timeout   = 400;
  localparam int hold_timeout   = 200;
  localparam int done_timeout   = 3000;
  localparam int drain_timeout  = 500;
  // a word this old has passed the synchronizer and sits in the spill register
  localparam int rr_age_ns      = 320;

  logic        src_clk_i;
  logic        dst_clk_i;
  logic        arst_n_i;
  logic [15:0] src0_data_i;
  logic        src0_last_i;
  logic        src0_valid_i;
  logic        src0_ready_o;
  logic [15:0] src1_data_i;
  logic        src1_last_i;
  logic        src1_valid_i;
  logic        src1_ready_o;
  logic [15:0] out_data_o;
  logic        out_src_o;
  logic        out_last_o;
  logic        out_valid_o;
  logic        out_ready_i;

  // expected entries hold {last, data, acceptance time in ns}
  logic [48:0] exp0_q [$];
  logic [48:0] exp1_q [$];
  int          accepted [2];
  logic        done0;
  logic        done1;
  logic        hold_active;
  int          errors;
  int          timeouts;
  int          beats;
  int          rr_checks;

  logic        pkt_open;
  int          open_ch;
  int          last_ch;
  logic        expect_switch;

  cdc_merge_top cdc_merge_top_i (
    .src_clk_i    (src_clk_i),
    .dst_clk_i    (dst_clk_i),
    .arst_n_i     (arst_n_i),
    .src0_data_i  (src0_data_i),
    .src0_last_i  (src0_last_i),
    .src0_valid_i (src0_valid_i),
    .src0_ready_o (src0_ready_o),
    .src1_data_i  (src1_data_i),
    .src1_last_i  (src1_last_i),
    .src1_valid_i (src1_valid_i),
    .src1_ready_o (src1_ready_o),
    .out_data_o   (out_data_o),
    .out_src_o    (out_src_o),
    .out_last_o   (out_last_o),
    .out_valid_o  (out_valid_o),
    .out_ready_i  (out_ready_i)
  );

  initial begin
    src_clk_i = 1'b0;
    forever #20 src_clk_i = ~src_clk_i;
  end

  // the destination clock is offset so its edges never meet the source edges
  initial begin
    dst_clk_i = 1'b0;
    #13;
    forever #20 dst_clk_i = ~dst_clk_i;
  end

  task automatic drive_channel(input int ch, input logic valid, input logic [15:0] word,
                               input logic last);
    if (ch == 0) begin
      src0_valid_i <= valid;
      src0_data_i  <= word;
      src0_last_i  <= last;
    end else begin
      src1_valid_i <= valid;
      src1_data_i  <= word;
      src1_last_i  <= last;
    end
  endtask

  function automatic logic channel_ready(input int ch);
    return (ch == 0) ? src0_ready_o : src1_ready_o;
  endfunction

  function automatic void push_expected(input int ch, input logic [48:0] entry);
    if (ch == 0) begin
      exp0_q.push_back(entry);
    end else begin
      exp1_q.push_back(entry);
    end
  endfunction

  function automatic int pending_beats(input int ch);
    return (ch == 0) ? exp0_q.size() : exp1_q.size();
  endfunction

  function automatic logic [48:0] peek_expected(input int ch);
    return (ch == 0) ? exp0_q[0] : exp1_q[0];
  endfunction

  function automatic void drop_expected(input int ch);
    if (ch == 0) begin
      void'(exp0_q.pop_front());
    end else begin
      void'(exp1_q.pop_front());
    end
  endfunction

  // offers every table row of one channel with no gap between the beats
  task automatic send_rows(input int ch);
    int          waited;
    logic [15:0] word;
    logic        last;
    @(posedge src_clk_i);
    for (int r = 0; r < num_rows; r++) begin
      if (int'(row_table[r].ch) == ch) begin
        if (!row_table[r].hold && hold_active) begin
          drive_channel(ch, 1'b0, 16'h0000, 1'b0);
          waited = 0;
          while (hold_active && waited < hold_timeout) begin
            @(posedge src_clk_i);
            waited++;
          end
          if (hold_active) begin
            $display("timeout: channel %0d waited too long for the output to be released", ch);
            timeouts++;
          end
        end
        for (int i = 0; i < int'(row_table[r].len); i++) begin
          word = row_table[r].start + 16'(i);
          last = (i == int'(row_table[r].len) - 1);
          drive_channel(ch, 1'b1, word, last);
          waited = 0;
          @(negedge src_clk_i);
          while (!channel_ready(ch) && waited < beat_timeout) begin
            @(negedge src_clk_i);
            waited++;
          end
          if (!channel_ready(ch)) begin
            $display("timeout: channel %0d never took word %h", ch, word);
            timeouts++;
            drive_channel(ch, 1'b0, 16'h0000, 1'b0);
            return;
          end
          // the beat is written on this edge
          @(posedge src_clk_i);
          push_expected(ch, {last, word, 32'($time)});
          accepted[ch]++;
        end
      end
    end
    drive_channel(ch, 1'b0, 16'h0000, 1'b0);
    if (ch == 0) begin
      done0 = 1'b1;
    end else begin
      done1 = 1'b1;
    end
  endtask

  // about 70% ready once the hold is lifted
  always @(posedge dst_clk_i) begin
    if (hold_active) begin
      out_ready_i <= 1'b0;
    end else begin
      out_ready_i <= ($urandom % 100) < 70;
    end
  end

  // values are stable at the falling edge and transfer on the next rising edge
  always @(negedge dst_clk_i) begin
    logic [48:0] head;
    logic [48:0] other_head;
    int          ch;
    int          other;
    if (arst_n_i && out_valid_o && out_ready_i) begin
      ch = int'(out_src_o);
      other = 1 - ch;
      if (pkt_open) begin
        assert (ch == open_ch) else begin
          $display("** Error at %0t: channel %0d cut into the open packet of channel %0d",
                   $time, ch, open_ch);
          errors++;
        end
      end else if (expect_switch) begin
        rr_checks++;
        assert (ch != last_ch) else begin
          $display("** Error at %0t: channel %0d went again while channel %0d was waiting",
                   $time, ch, other);
          errors++;
        end
      end
      if (pending_beats(ch) == 0) begin
        $display("** Error at %0t: channel %0d sent word %h that was never offered",
                 $time, ch, out_data_o);
        errors++;
      end else begin
        head = peek_expected(ch);
        drop_expected(ch);
        beats++;
        assert (out_data_o == head[47:32] && out_last_o == head[48]) else begin
          $display("** Error at %0t: channel %0d gave %h last %b, expected %h last %b",
                   $time, ch, out_data_o, out_last_o, head[47:32], head[48]);
          errors++;
        end
      end
      if (out_last_o) begin
        pkt_open      = 1'b0;
        last_ch       = ch;
        expect_switch = 1'b0;
        if (pending_beats(other) > 0) begin
          other_head = peek_expected(other);
          // the other channel must win next if its oldest word is already waiting
          expect_switch = (int'($time) - int'(other_head[31:0])) >= rr_age_ns;
        end
      end else begin
        pkt_open = 1'b1;
        open_ch  = ch;
      end
    end
  end

  initial begin
    int held [2];
    int exp_acc;
    int waited;
    src0_data_i   = '0;
    src0_last_i   = 1'b0;
    src0_valid_i  = 1'b0;
    src1_data_i   = '0;
    src1_last_i   = 1'b0;
    src1_valid_i  = 1'b0;
    out_ready_i   = 1'b0;
    arst_n_i      = 1'b0;
    hold_active   = 1'b1;
    done0         = 1'b0;
    done1         = 1'b0;
    errors        = 0;
    timeouts      = 0;
    beats         = 0;
    rr_checks     = 0;
    pkt_open      = 1'b0;
    open_ch       = 0;
    last_ch       = 0;
    expect_switch = 1'b0;
    accepted[0]   = 0;
    accepted[1]   = 0;
    held[0]       = 0;
    held[1]       = 0;
    void'($urandom(32'h44150b19));

    for (int r = 0; r < num_rows; r++) begin
      if (row_table[r].hold) begin
        held[row_table[r].ch] += int'(row_table[r].len);
      end
    end

    for (int i = 0; i < 4; i++) begin
      @(negedge src_clk_i);
      assert (!out_valid_o && !src0_ready_o && !src1_ready_o) else begin
        $display("** Error at %0t: outputs active in reset, valid %b ready %b %b",
                 $time, out_valid_o, src0_ready_o, src1_ready_o);
        errors++;
      end
    end
    @(posedge src_clk_i);
    arst_n_i <= 1'b1;

    fork
      send_rows(0);
      send_rows(1);
    join_none

    // a channel with more held beats than the FIFO path can store must stall
    for (int c = 0; c < bp_window; c++) begin
      @(negedge src_clk_i);
      if (c >= bp_window - ready_low_span) begin
        if (held[0] > fifo_beats) begin
          assert (!src0_ready_o) else begin
            $display("** Error at %0t: channel 0 ready high with the output held", $time);
            errors++;
          end
        end
        if (held[1] > fifo_beats) begin
          assert (!src1_ready_o) else begin
            $display("** Error at %0t: channel 1 ready high with the output held", $time);
            errors++;
          end
        end
      end
    end
    for (int c = 0; c < 2; c++) begin
      exp_acc = (held[c] > fifo_beats) ? fifo_beats : held[c];
      assert (accepted[c] == exp_acc) else begin
        $display("** Error at %0t: channel %0d took %0d beats under hold, expected %0d",
                 $time, c, accepted[c], exp_acc);
        errors++;
      end
    end
    hold_active = 1'b0;

    waited = 0;
    while (!(done0 && done1) && waited < done_timeout) begin
      @(posedge src_clk_i);
      waited++;
    end
    if (!(done0 && done1)) begin
      $display("timeout: the senders did not get all their packets in");
      timeouts++;
    end

    waited = 0;
    while ((exp0_q.size() > 0 || exp1_q.size() > 0) && waited < drain_timeout) begin
      @(posedge dst_clk_i);
      waited++;
    end
    if (exp0_q.size() > 0 || exp1_q.size() > 0) begin
      $display("timeout: the output did not deliver every accepted word");
      timeouts++;
    end
    repeat (10) @(posedge dst_clk_i);

    assert (exp0_q.size() == 0 && exp1_q.size() == 0 && !pkt_open) else begin
      $display("** Error at %0t: %0d and %0d words still expected at the end",
               $time, exp0_q.size(), exp1_q.size());
      errors++;
    end
    if (rr_checks == 0) begin
      $display("round robin was never exercised with both channels waiting");
      errors++;
    end

    $display("errors %0d, timeouts %0d, beats checked %0d, round robin checks %0d",
             errors, timeouts, beats, rr_checks);
    if (errors == 0 && timeouts == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire
